// ==== source/redundancy_settings.svh ====
`ifndef REDUNDANCY_SETTINGS_SVH
`define REDUNDANCY_SETTINGS_SVH

// Width of each operand
`define RA_OPERAND_W 16

// Width of a result
// Wide enough for the full 16x16 product
`define RA_RESULT_W 32

// Copy ID width
// Results stay in order so two bits are plenty
`define RA_ID_W 2

// Register slices in the compute pipeline
`define RA_PIPE_DEPTH 2

`endif

// ==== source/voters.svh ====
`ifndef VOTERS_SVH
`define VOTERS_SVH

// Bitwise majority of three replicas into one value
// Works on single bits and on packed vectors alike
`define VOTE3to1(vote_in, vote_out) \
    vote_out = ((vote_in[0] & vote_in[1]) | \
                (vote_in[0] & vote_in[2]) | \
                (vote_in[1] & vote_in[2]))

// Majority of three replicas written back to all three
`define VOTE3to3(vote_in, vote_out) \
    `VOTE3to1(vote_in, vote_out[0]); \
    `VOTE3to1(vote_in, vote_out[1]); \
    `VOTE3to1(vote_in, vote_out[2])

// Enum arrays are voted by comparison instead of bitwise
`define VOTE3to3ENUM(vote_in, vote_out) \
    vote_out[0] = ((vote_in[0] == vote_in[1]) || (vote_in[0] == vote_in[2])) ? \
                  vote_in[0] : vote_in[1]; \
    vote_out[1] = ((vote_in[0] == vote_in[1]) || (vote_in[0] == vote_in[2])) ? \
                  vote_in[0] : vote_in[1]; \
    vote_out[2] = ((vote_in[0] == vote_in[1]) || (vote_in[0] == vote_in[2])) ? \
                  vote_in[0] : vote_in[1]

`endif

// ==== source/redundancy_pkg.sv ====
`include "redundancy_settings.svh"

package redundancy_pkg;

    // Operations of the arithmetic unit
    typedef enum logic [1:0] {
        OP_ADD = 2'd0,
        OP_SUB = 2'd1,
        OP_MUL = 2'd2,
        OP_XOR = 2'd3
    } alu_op_e;

    // Request from the start stage into the pipeline, 34 bits
    typedef struct packed {
        alu_op_e                  op;
        logic [`RA_OPERAND_W-1:0] a;
        logic [`RA_OPERAND_W-1:0] b;
    } alu_req_t;

    // Response from the pipeline into the end stage
    typedef struct packed {
        logic [`RA_RESULT_W-1:0] result;
    } alu_rsp_t;

    // Handshake states of the end stage
    typedef enum logic [1:0] {
        BASE,
        WAIT_FOR_READY,
        WAIT_FOR_VALID
    } dmr_state_e;

endpackage

// ==== source/stream_if.sv ====
`include "redundancy_settings.svh"

// Valid/ready link with a typed payload and a copy ID
interface stream_if #(
    parameter type payload_t = logic
) ();

    // Held stable by the sender while valid is high and ready is low
    payload_t            payload;
    logic [`RA_ID_W-1:0] id;
    logic                valid;

    // Driven by the receiver
    logic                ready;

    modport sender (
        output payload,
        output id,
        output valid,
        input  ready
    );

    modport receiver (
        input  payload,
        input  id,
        input  valid,
        output ready
    );

endinterface

// ==== source/stream_register.sv ====
`include "redundancy_settings.svh"

module stream_register #(
    parameter type payload_t = logic
) (
    input  logic       clk_i,
    input  logic       rst_ni,
    stream_if.receiver in,
    stream_if.sender   out
);

    logic                valid_q;
    payload_t            payload_q;
    logic [`RA_ID_W-1:0] id_q;

    // Free slot, or the held item leaves in this cycle
    assign in.ready = ~valid_q | out.ready;

    // Occupancy flag
    always_ff @(posedge clk_i or negedge rst_ni) begin : valid_ff
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else if (in.valid && in.ready) begin
            valid_q <= 1'b1;
        end else if (out.ready) begin
            valid_q <= 1'b0;
        end
    end

    // Payload and ID load on an input transfer only
    always_ff @(posedge clk_i) begin : payload_ff
        if (in.valid && in.ready) begin
            payload_q <= in.payload;
            id_q      <= in.id;
        end
    end

    assign out.valid   = valid_q;
    assign out.payload = payload_q;
    assign out.id      = id_q;

endmodule

// ==== source/time_dmr_start.sv ====
`include "redundancy_settings.svh"

module time_dmr_start (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     enable_i,
    input  redundancy_pkg::alu_op_e  op_i,
    input  logic [`RA_OPERAND_W-1:0] a_i,
    input  logic [`RA_OPERAND_W-1:0] b_i,
    input  logic                     valid_i,
    output logic                     ready_o,
    stream_if.sender                 out,
    output logic [`RA_ID_W-1:0]      next_id_o
);
    import redundancy_pkg::*;

    // Copy counter encoding
    localparam logic [1:0] COPY_IDLE   = 2'd0;
    localparam logic [1:0] COPY_FIRST  = 2'd1;
    localparam logic [1:0] COPY_SECOND = 2'd2;

    logic [1:0]          copy_d;
    logic [1:0]          copy_q;
    alu_req_t            req_q;
    logic [`RA_ID_W-1:0] id_q;
    logic [`RA_ID_W-1:0] next_id_q;
    logic                accept;
    logic                sent;

    // New work only while no copy is pending
    assign ready_o = (copy_q == COPY_IDLE);
    assign accept  = valid_i & ready_o;
    assign sent    = out.valid & out.ready;

    always_comb begin : copy_next_comb
        copy_d = copy_q;
        case (copy_q)
            COPY_IDLE: begin
                if (accept) begin
                    copy_d = COPY_FIRST;
                end
            end
            COPY_FIRST: begin
                // Bypass mode sends a single copy
                if (sent) begin
                    copy_d = enable_i ? COPY_SECOND : COPY_IDLE;
                end
            end
            COPY_SECOND: begin
                if (sent) begin
                    copy_d = COPY_IDLE;
                end
            end
            default: copy_d = COPY_IDLE;
        endcase
    end

    // Counter and ID source
    always_ff @(posedge clk_i or negedge rst_ni) begin : control_ff
        if (!rst_ni) begin
            copy_q    <= COPY_IDLE;
            next_id_q <= '0;
        end else begin
            copy_q <= copy_d;
            if (accept) begin
                next_id_q <= next_id_q + `RA_ID_W'(1);
            end
        end
    end

    // Latched operation, both copies share it and its ID
    always_ff @(posedge clk_i) begin : request_ff
        if (accept) begin
            req_q <= '{op: op_i, a: a_i, b: b_i};
            id_q  <= next_id_q;
        end
    end

    assign out.valid   = (copy_q != COPY_IDLE);
    assign out.payload = req_q;
    assign out.id      = id_q;

    // End stage clears its dedup entry for this ID ahead of reuse
    assign next_id_o = next_id_q;

endmodule

// ==== source/alu_pipeline.sv ====
`include "redundancy_settings.svh"

module alu_pipeline (
    input  logic       clk_i,
    input  logic       rst_ni,
    input  logic       fault_inject_i,
    stream_if.receiver in,
    stream_if.sender   out
);
    import redundancy_pkg::*;

    ////////////////////////////////////////////////////////////
    // Arithmetic

    // Zero-extended operands, add and sub wrap at the result width
    function automatic alu_rsp_t evaluate(alu_req_t req);
        alu_rsp_t                rsp;
        logic [`RA_RESULT_W-1:0] a_ext;
        logic [`RA_RESULT_W-1:0] b_ext;
        a_ext = `RA_RESULT_W'(req.a);
        b_ext = `RA_RESULT_W'(req.b);
        case (req.op)
            OP_ADD:  rsp.result = a_ext + b_ext;
            OP_SUB:  rsp.result = a_ext - b_ext;
            OP_MUL:  rsp.result = a_ext * b_ext;
            OP_XOR:  rsp.result = a_ext ^ b_ext;
            default: rsp.result = '0;
        endcase
        return rsp;
    endfunction

    ////////////////////////////////////////////////////////////
    // Two register slices with the evaluation between them

    stream_if #(.payload_t(alu_req_t)) req_q ();
    stream_if #(.payload_t(alu_rsp_t)) rsp_d ();

    alu_rsp_t rsp_calc;

    stream_register #(.payload_t(alu_req_t)) req_slice_i (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .in     (in),
        .out    (req_q)
    );

    always_comb begin : evaluate_comb
        rsp_calc = evaluate(req_q.payload);
        // Fault hook flips bit 0 of the item entering the second slice
        rsp_calc.result[0] = rsp_calc.result[0] ^ fault_inject_i;
    end

    assign rsp_d.payload = rsp_calc;
    assign rsp_d.id      = req_q.id;
    assign rsp_d.valid   = req_q.valid;
    assign req_q.ready   = rsp_d.ready;

    stream_register #(.payload_t(alu_rsp_t)) rsp_slice_i (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .in     (rsp_d),
        .out    (out)
    );

endmodule

// ==== source/time_dmr_end.sv ====
`include "redundancy_settings.svh"
`include "voters.svh"

module time_dmr_end (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    enable_i,
    input  logic [`RA_ID_W-1:0]     next_id_i,
    stream_if.receiver              in,
    output logic [`RA_RESULT_W-1:0] result_o,
    output logic                    valid_o,
    input  logic                    ready_i,
    output logic                    needs_retry_o,
    output logic                    fault_detected_o
);
    import redundancy_pkg::*;

    localparam int ID_COUNT = 2 ** `RA_ID_W;

    ////////////////////////////////////////////////////////////
    // Last arrival

    alu_rsp_t            data_q;
    logic [`RA_ID_W-1:0] id_q;
    logic                in_ready;
    logic                arrive;

    // Arrivals only count while redundancy is on
    assign arrive   = in.valid & in_ready & enable_i;
    assign in.ready = in_ready;

    always_ff @(posedge clk_i) begin : data_storage_ff
        if (arrive) begin
            data_q <= in.payload;
        end
    end

    // Starts on the last ID so the first copy is never taken for a second one
    always_ff @(posedge clk_i or negedge rst_ni) begin : id_storage_ff
        if (!rst_ni) begin
            id_q <= '1;
        end else if (arrive) begin
            id_q <= in.id;
        end
    end

    ////////////////////////////////////////////////////////////
    // Same / not same over two arrivals

    logic [2:0] id_same_in;
    logic [2:0] data_same_in;
    logic [2:0] pair_done;
    logic [2:0] id_same_v;
    logic [2:0] id_same_d;
    logic [2:0] id_same_q;

    always_comb begin : compare_comb
        for (int r = 0; r < 3; r++) begin
            id_same_in[r]   = (in.id == id_q);
            data_same_in[r] = (in.payload == data_q);
            // Second copy of the stored item is at the input
            pair_done[r]    = in.valid & id_same_in[r];
            id_same_v[r]    = arrive ? id_same_in[r] : id_same_q[r];
        end
        `VOTE3to3(id_same_v, id_same_d);
    end

    ////////////////////////////////////////////////////////////
    // Handshake FSM, three replicas

    dmr_state_e state_v [3];
    dmr_state_e state_d [3];
    dmr_state_e state_q [3];

    always_comb begin : next_state_comb
        for (int r = 0; r < 3; r++) begin
            state_v[r] = state_q[r];
            if (!enable_i) begin
                // Re-enable starts on a fresh pair
                state_v[r] = WAIT_FOR_VALID;
            end else begin
                case (state_q[r])
                    WAIT_FOR_VALID: begin
                        if (in.valid) begin
                            state_v[r] = BASE;
                        end
                    end
                    BASE: begin
                        if (pair_done[r] && (ready_i || !data_same_in[r])) begin
                            state_v[r] = WAIT_FOR_VALID;
                        end else if (pair_done[r]) begin
                            state_v[r] = WAIT_FOR_READY;
                        end
                    end
                    WAIT_FOR_READY: begin
                        if (ready_i) begin
                            state_v[r] = WAIT_FOR_VALID;
                        end
                    end
                    default: state_v[r] = WAIT_FOR_VALID;
                endcase
            end
        end
        `VOTE3to3ENUM(state_v, state_d);
    end

    ////////////////////////////////////////////////////////////
    // Outputs and deduplication

    logic [2:0]                   valid_int;
    logic [2:0]                   valid_ov;
    logic [2:0]                   ready_ov;
    logic [2:0]                   retry_ov;
    logic [2:0][`RA_RESULT_W-1:0] result_ov;
    logic [2:0][ID_COUNT-1:0]     seen_v;
    logic [2:0][ID_COUNT-1:0]     seen_d;
    logic [2:0][ID_COUNT-1:0]     seen_q;

    always_comb begin : output_comb
        for (int r = 0; r < 3; r++) begin
            if (enable_i) begin
                case (state_q[r])
                    BASE: begin
                        valid_int[r] = pair_done[r] & data_same_in[r];
                        // Second copy stays at the input until downstream takes the result
                        ready_ov[r]  = ready_i | ~valid_int[r];
                        retry_ov[r]  = pair_done[r] & ~data_same_in[r];
                    end
                    WAIT_FOR_READY: begin
                        valid_int[r] = in.valid;
                        ready_ov[r]  = ready_i;
                        retry_ov[r]  = 1'b0;
                    end
                    default: begin
                        valid_int[r] = 1'b0;
                        ready_ov[r]  = 1'b1;
                        retry_ov[r]  = 1'b0;
                    end
                endcase
                valid_ov[r]  = valid_int[r] & ~seen_q[r][id_q];
                result_ov[r] = data_q.result;
            end else begin
                // Bypass straight through
                valid_int[r] = in.valid;
                valid_ov[r]  = in.valid;
                ready_ov[r]  = ready_i;
                retry_ov[r]  = 1'b0;
                result_ov[r] = in.payload.result;
            end
        end
        `VOTE3to1(ready_ov, in_ready);
        `VOTE3to1(valid_ov, valid_o);
        `VOTE3to1(retry_ov, needs_retry_o);
        `VOTE3to1(result_ov, result_o);
    end

    always_comb begin : seen_comb
        for (int r = 0; r < 3; r++) begin
            seen_v[r] = seen_q[r];
            // Entry about to be handed out again by the start stage
            seen_v[r][next_id_i] = 1'b0;
            if (enable_i && valid_int[r] && ready_i) begin
                seen_v[r][id_q] = 1'b1;
            end
        end
        `VOTE3to3(seen_v, seen_d);
    end

    ////////////////////////////////////////////////////////////
    // Fault flag

    logic [2:0] fault_v;
    logic       fault_d;
    logic       fault_q;

    // Neither this arrival nor the one before it closed a matching pair
    always_comb begin : fault_comb
        for (int r = 0; r < 3; r++) begin
            fault_v[r] = arrive & ~(id_same_in[r] & data_same_in[r]) & ~id_same_q[r];
        end
        `VOTE3to1(fault_v, fault_d);
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin : state_ff
        if (!rst_ni) begin
            state_q   <= '{default: WAIT_FOR_VALID};
            id_same_q <= '1;
            seen_q    <= '0;
            fault_q   <= 1'b0;
        end else begin
            state_q   <= state_d;
            id_same_q <= id_same_d;
            seen_q    <= seen_d;
            fault_q   <= fault_d;
        end
    end

    // Rising edge only
    assign fault_detected_o = fault_d & ~fault_q;

endmodule

// ==== source/redundant_alu_top.sv ====
`include "redundancy_settings.svh"

module redundant_alu_top (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     enable_i,
    input  redundancy_pkg::alu_op_e  op_i,
    input  logic [`RA_OPERAND_W-1:0] a_i,
    input  logic [`RA_OPERAND_W-1:0] b_i,
    input  logic                     valid_i,
    output logic                     ready_o,
    input  logic                     fault_inject_i,
    output logic [`RA_RESULT_W-1:0]  result_o,
    output logic                     valid_o,
    input  logic                     ready_i,
    output logic                     needs_retry_o,
    output logic                     fault_detected_o
);
    import redundancy_pkg::*;

    // Direct ID link for deduplication
    logic [`RA_ID_W-1:0] next_id;

    stream_if #(.payload_t(alu_req_t)) start_to_alu ();
    stream_if #(.payload_t(alu_rsp_t)) alu_to_end ();

    time_dmr_start time_dmr_start_i (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .enable_i  (enable_i),
        .op_i      (op_i),
        .a_i       (a_i),
        .b_i       (b_i),
        .valid_i   (valid_i),
        .ready_o   (ready_o),
        .out       (start_to_alu),
        .next_id_o (next_id)
    );

    alu_pipeline alu_pipeline_i (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .fault_inject_i (fault_inject_i),
        .in             (start_to_alu),
        .out            (alu_to_end)
    );

    time_dmr_end time_dmr_end_i (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .enable_i         (enable_i),
        .next_id_i        (next_id),
        .in               (alu_to_end),
        .result_o         (result_o),
        .valid_o          (valid_o),
        .ready_i          (ready_i),
        .needs_retry_o    (needs_retry_o),
        .fault_detected_o (fault_detected_o)
    );

endmodule

// ==== test/redundant_alu_properties.sv ====
`include "redundancy_settings.svh"

module redundant_alu_properties (
    input logic                    clk_i,
    input logic                    rst_ni,
    input logic [`RA_RESULT_W-1:0] result_o,
    input logic                    valid_o,
    input logic                    ready_i,
    input logic                    needs_retry_o,
    input logic                    fault_detected_o
);

    // Failed assertions so far
    int fail_count = 0;

    // Result held under back-pressure
    result_held_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        valid_o && !ready_i |=> valid_o && $stable(result_o))
        else begin
            fail_count++;
            $error("result_o or valid_o changed while the output was stalled");
        end

    // A retry never comes with a result
    retry_excl_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(needs_retry_o && valid_o))
        else begin
            fail_count++;
            $error("needs_retry_o and valid_o high together");
        end

    // Fault flag is a single-cycle pulse that marks a retry
    fault_pulse_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        fault_detected_o |-> needs_retry_o && !$past(fault_detected_o))
        else begin
            fail_count++;
            $error("fault_detected_o without a retry or high on two cycles in a row");
        end

    // Quiet outputs right after reset
    reset_flags_a: assert property (@(posedge clk_i)
        $rose(rst_ni) |-> !valid_o && !needs_retry_o && !fault_detected_o)
        else begin
            fail_count++;
            $error("output flags not low after reset");
        end

endmodule

bind redundant_alu_top redundant_alu_properties redundant_alu_properties_i (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .result_o         (result_o),
    .valid_o          (valid_o),
    .ready_i          (ready_i),
    .needs_retry_o    (needs_retry_o),
    .fault_detected_o (fault_detected_o)
);

// ==== test/tb_redundant_alu.sv ====
`include "redundancy_settings.svh"

module tb_redundant_alu;
    import redundancy_pkg::*;

    localparam int NUM_ROWS        = 16;
    localparam int RESET_CYCLES    = 10;
    localparam int DRAIN_CYCLES    = 20;
    // Budget per row grows with the pipeline depth
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + DRAIN_CYCLES + NUM_ROWS * 20 * `RA_PIPE_DEPTH;

    logic                     clk_i;
    logic                     rst_ni;
    logic                     enable_i;
    alu_op_e                  op_i;
    logic [`RA_OPERAND_W-1:0] a_i;
    logic [`RA_OPERAND_W-1:0] b_i;
    logic                     valid_i;
    logic                     ready_o;
    logic                     fault_inject_i;
    logic [`RA_RESULT_W-1:0]  result_o;
    logic                     valid_o;
    logic                     ready_i;
    logic                     needs_retry_o;
    logic                     fault_detected_o;

    // Stimulus table, one entry per operation
    string                    row_name     [NUM_ROWS];
    alu_op_e                  row_op       [NUM_ROWS];
    logic [`RA_OPERAND_W-1:0] row_a        [NUM_ROWS];
    logic [`RA_OPERAND_W-1:0] row_b        [NUM_ROWS];
    logic                     row_inject   [NUM_ROWS];
    logic                     row_enable   [NUM_ROWS];
    logic                     row_rand     [NUM_ROWS];
    logic                     row_retry    [NUM_ROWS];
    logic [`RA_RESULT_W-1:0]  row_expected [NUM_ROWS];

    // Observed outcomes in arrival order
    logic                     got_retry [$];
    logic [`RA_RESULT_W-1:0]  got_value [$];

    int seed        = 86623;
    int rand_word;
    int row_fill    = 0;
    int current_row = 0;
    int fault_count = 0;
    int check_count = 0;
    int error_count = 0;
    bit use_random_ready;

    redundant_alu_top redundant_alu_top_i (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .enable_i         (enable_i),
        .op_i             (op_i),
        .a_i              (a_i),
        .b_i              (b_i),
        .valid_i          (valid_i),
        .ready_o          (ready_o),
        .fault_inject_i   (fault_inject_i),
        .result_o         (result_o),
        .valid_o          (valid_o),
        .ready_i          (ready_i),
        .needs_retry_o    (needs_retry_o),
        .fault_detected_o (fault_detected_o)
    );

    ////////////////////////////////////////////////////////////
    // Reference arithmetic and table

    // Zero-extended operands, wrap at the result width
    function automatic logic [`RA_RESULT_W-1:0] rule_result(alu_op_e op,
                                                            logic [`RA_OPERAND_W-1:0] a,
                                                            logic [`RA_OPERAND_W-1:0] b);
        logic [`RA_RESULT_W-1:0] wa;
        logic [`RA_RESULT_W-1:0] wb;
        wa = {{(`RA_RESULT_W-`RA_OPERAND_W){1'b0}}, a};
        wb = {{(`RA_RESULT_W-`RA_OPERAND_W){1'b0}}, b};
        case (op)
            OP_ADD:  return wa + wb;
            OP_SUB:  return wa - wb;
            OP_MUL:  return wa * wb;
            default: return wa ^ wb;
        endcase
    endfunction

    task automatic add_row(input string name, input alu_op_e op,
                           input logic [`RA_OPERAND_W-1:0] a, b,
                           input logic inject, enable, rand_ready);
        row_name[row_fill]     = name;
        row_op[row_fill]       = op;
        row_a[row_fill]        = a;
        row_b[row_fill]        = b;
        row_inject[row_fill]   = inject;
        row_enable[row_fill]   = enable;
        row_rand[row_fill]     = rand_ready;
        // Redundant mode catches the flip, bypass passes it on
        row_retry[row_fill]    = inject & enable;
        row_expected[row_fill] = rule_result(op, a, b);
        if (inject && !enable) begin
            row_expected[row_fill][0] = ~row_expected[row_fill][0];
        end
        row_fill++;
    endtask

    task automatic fill_table();
        add_row("add_basic",        OP_ADD, 16'h1234, 16'h0F0F, 1'b0, 1'b1, 1'b0);
        add_row("sub_basic",        OP_SUB, 16'h9000, 16'h1001, 1'b0, 1'b1, 1'b0);
        add_row("mul_basic",        OP_MUL, 16'h00FF, 16'h0101, 1'b0, 1'b1, 1'b0);
        add_row("xor_basic",        OP_XOR, 16'hA5A5, 16'h0FF0, 1'b0, 1'b1, 1'b0);
        add_row("add_fault",        OP_ADD, 16'h7FFF, 16'h0001, 1'b1, 1'b1, 1'b1);
        add_row("add_resend",       OP_ADD, 16'h7FFF, 16'h0001, 1'b0, 1'b1, 1'b1);
        // Identical operands on distinct IDs
        add_row("mul_same_a",       OP_MUL, 16'h1357, 16'h2468, 1'b0, 1'b1, 1'b1);
        add_row("mul_same_b",       OP_MUL, 16'h1357, 16'h2468, 1'b0, 1'b1, 1'b1);
        add_row("mul_same_c",       OP_MUL, 16'h1357, 16'h2468, 1'b0, 1'b1, 1'b1);
        add_row("sub_bypass",       OP_SUB, 16'h0003, 16'h0005, 1'b0, 1'b0, 1'b1);
        add_row("xor_bypass_fault", OP_XOR, 16'hFFFF, 16'h1234, 1'b1, 1'b0, 1'b1);
        add_row("xor_fault",        OP_XOR, 16'h00F0, 16'h0F00, 1'b1, 1'b1, 1'b1);
        add_row("xor_resend",       OP_XOR, 16'h00F0, 16'h0F00, 1'b0, 1'b1, 1'b1);
        add_row("sub_wrap",         OP_SUB, 16'h0001, 16'hFFFF, 1'b0, 1'b1, 1'b1);
        add_row("add_carry",        OP_ADD, 16'hFFFF, 16'hFFFF, 1'b0, 1'b1, 1'b1);
        add_row("mul_max",          OP_MUL, 16'hFFFF, 16'hFFFF, 1'b0, 1'b1, 1'b1);
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            $display("MISMATCH %s expected %h actual %h", what, expected, actual);
            error_count++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Clock, ready source, monitor, watchdog

    initial begin : clock_gen
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    initial begin : ready_driver
        forever begin
            @(posedge clk_i);
            rand_word = $random(seed);
            ready_i <= use_random_ready ? rand_word[0] : 1'b1;
        end
    end

    // Falling edge sees settled outputs of the current cycle
    always @(negedge clk_i) begin : outcome_monitor
        if (rst_ni) begin
            if (needs_retry_o) begin
                got_retry.push_back(1'b1);
                got_value.push_back('0);
            end else if (valid_o && ready_i) begin
                got_retry.push_back(1'b0);
                got_value.push_back(result_o);
            end
            if (fault_detected_o) begin
                fault_count++;
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        $display("Timeout: row %0d produced no result or retry in time", current_row);
        $display("Test FAILED");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // Row sequencing

    task automatic run_row(input int i);
        int                      faults_before;
        logic                    retry_seen;
        logic [`RA_RESULT_W-1:0] value_seen;
        current_row      = i;
        faults_before    = fault_count;
        use_random_ready <= row_rand[i];
        enable_i         <= row_enable[i];
        op_i             <= row_op[i];
        a_i              <= row_a[i];
        b_i              <= row_b[i];
        valid_i          <= 1'b1;
        @(negedge clk_i);
        while (!ready_o) @(negedge clk_i);
        // Accepted on this edge
        @(posedge clk_i);
        valid_i <= 1'b0;
        // Copy one enters the second slice two edges after acceptance
        @(posedge clk_i);
        fault_inject_i <= row_inject[i];
        @(posedge clk_i);
        fault_inject_i <= 1'b0;
        while (got_retry.size() == 0) @(posedge clk_i);
        retry_seen = got_retry.pop_front();
        value_seen = got_value.pop_front();
        check_value({row_name[i], " retry"}, 32'(row_retry[i]), 32'(retry_seen));
        if (!row_retry[i]) begin
            check_value({row_name[i], " result"}, row_expected[i], value_seen);
        end
        check_value({row_name[i], " faults"}, 32'(row_retry[i]), fault_count - faults_before);
    endtask

    initial begin : main_flow
        rst_ni           = 1'b0;
        enable_i         = 1'b1;
        op_i             = OP_ADD;
        a_i              = '0;
        b_i              = '0;
        valid_i          = 1'b0;
        ready_i          = 1'b1;
        fault_inject_i   = 1'b0;
        use_random_ready = 1'b0;
        fill_table();
        repeat (RESET_CYCLES) @(posedge clk_i);
        rst_ni <= 1'b1;
        @(negedge clk_i);
        // ready_o, valid_o, needs_retry_o, fault_detected_o
        check_value("reset flags", 32'h8,
                    {28'h0, ready_o, valid_o, needs_retry_o, fault_detected_o});
        @(posedge clk_i);
        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(i);
        end
        repeat (DRAIN_CYCLES) @(posedge clk_i);
        if (got_retry.size() != 0) begin
            $display("Extra output after the last row: %0d item(s)", got_retry.size());
            error_count++;
        end
        // Failures of the bound protocol assertions
        error_count += redundant_alu_top_i.redundant_alu_properties_i.fail_count;
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+source
source/redundancy_pkg.sv
source/stream_if.sv
source/stream_register.sv
source/time_dmr_start.sv
source/alu_pipeline.sv
source/time_dmr_end.sv
source/redundant_alu_top.sv
test/redundant_alu_properties.sv
test/tb_redundant_alu.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_redundant_alu
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
PASS_MSG  = Test OK

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

# The run passes only if the pass line shows up in the output
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
